/* common/writeback_pkg.sv */
`default_nettype none

package writeback_pkg;

    // Ordering tag width, must count at least the number of sources
    localparam int STATUS_WIDTH = 2;

    // Execute, load path, system unit
    localparam int NUM_SOURCES = 3;

    // Architectural register number, wide enough for RV32I
    typedef logic [4:0] reg_addr_t;

    // Per-register ordering tag, wraps modulo 2**STATUS_WIDTH
    typedef logic [STATUS_WIDTH-1:0] reg_status_t;

    // Finished result headed for the register file
    typedef struct packed {
        reg_addr_t   dest;
        reg_status_t status;
        logic [31:0] value;
    } wb_result_t;

    // Load access size
    typedef enum logic [1:0] {
        LOAD_BYTE = 2'b00,
        LOAD_HALF = 2'b01,
        LOAD_WORD = 2'b10
    } load_size_t;

    // Load command from the memory path
    // The raw data word travels next to it on its own wire
    typedef struct packed {
        reg_addr_t   dest;
        reg_status_t status;
        load_size_t  size;
        logic        is_signed;
        logic [1:0]  offset;
    } mem_cmd_t;

endpackage

`default_nettype wire

/* writeback/load_aligner.sv */
`timescale 1ns/10ps
`default_nettype none

// Moves the addressed bytes of a raw load word down to bit 0
// and extends them to a full register value
module load_aligner
    import writeback_pkg::*;
(
    input  wire logic        valid,
    input  wire mem_cmd_t    cmd,
    input  wire logic [31:0] data,
    output wb_result_t       result
);

    logic [31:0] shifted;
    logic        sign_bit;

    // Byte lane select
    assign shifted = data >> {cmd.offset, 3'b000};

    always_comb begin
        result.dest   = cmd.dest;
        result.status = cmd.status;

        case (cmd.size)
            LOAD_BYTE: begin
                sign_bit     = cmd.is_signed & shifted[7];
                result.value = {{24{sign_bit}}, shifted[7:0]};
            end
            LOAD_HALF: begin
                sign_bit     = cmd.is_signed & shifted[15];
                result.value = {{16{sign_bit}}, shifted[15:0]};
            end
            default: begin
                // Full word, nothing to extend
                sign_bit     = 1'b0;
                result.value = shifted;
            end
        endcase
    end

    // Misaligned accesses are split or trapped before they get here
    always_comb begin
        assert final (!valid
                      || ((cmd.size != LOAD_HALF || !cmd.offset[0])
                          && (cmd.size != LOAD_WORD || cmd.offset == 2'b00)))
        else $error("load_aligner: misaligned load, size %0d offset %0d",
                    cmd.size, cmd.offset);
    end

endmodule

`default_nettype wire

/* writeback/reg_status_table.sv */
`timescale 1ns/10ps
`default_nettype none

// Local copy of the expected ordering tag for each register
module reg_status_table
    import writeback_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  wire logic                  clk,
    input  wire logic                  rst,

    input  wire reg_addr_t   [2:0]     rd_addr,
    output reg_status_t      [2:0]     rd_status,

    input  wire logic                  wr_en,
    input  wire reg_addr_t             wr_addr,
    input  wire reg_status_t           wr_status,

    output logic                       table_ready
);

    localparam int IDX_WIDTH = $clog2(NUM_REGS);

    reg_status_t          status_mem [NUM_REGS];
    logic [IDX_WIDTH-1:0] sweep_idx;

    // Clearing sweep, one entry per cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_idx   <= '0;
            table_ready <= 1'b0;
        end else if (!table_ready) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == IDX_WIDTH'(NUM_REGS - 1)) begin
                table_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst && !table_ready) begin
            status_mem[sweep_idx] <= '0;
        end else if (wr_en) begin
            status_mem[wr_addr[IDX_WIDTH-1:0]] <= wr_status;
        end
    end

    // Three combinational read ports
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            if (rd_addr[i] < NUM_REGS) begin
                rd_status[i] = status_mem[rd_addr[i][IDX_WIDTH-1:0]];
            end else begin
                // Registers beyond RV32E never match a real tag stream
                rd_status[i] = '0;
            end
        end
    end

    // Arbiter only writes once the sweep has finished
    a_write_after_sweep: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> table_ready
    ) else $error("reg_status_table: write before table_ready");

    a_write_in_range: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> (wr_addr < NUM_REGS)
    ) else $error("reg_status_table: write to register %0d", wr_addr);

endmodule

`default_nettype wire

/* writeback/writeback_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

// Round-robin pick among execute, load and system results
// A result only goes out when its tag is the next one for its register
module writeback_arbiter
    import writeback_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,

    input  wire logic              exec_valid,
    output logic                   exec_ready,
    input  wire wb_result_t        exec_result,

    input  wire logic              mem_valid,
    output logic                   mem_ready,
    input  wire wb_result_t        mem_result,

    input  wire logic              sys_valid,
    output logic                   sys_ready,
    input  wire wb_result_t        sys_result,

    output reg_addr_t   [2:0]      rd_addr,
    input  wire reg_status_t [2:0] rd_status,
    output logic                   wr_en,
    output reg_addr_t              wr_addr,
    output reg_status_t            wr_status,
    input  wire logic              table_ready,

    output logic                   out_valid,
    input  wire logic              out_ready,
    output wb_result_t             out_result
);

    // Source order: 0 execute, 1 load, 2 system
    wb_result_t                   src_result [NUM_SOURCES];
    logic [NUM_SOURCES-1:0]       src_valid;
    logic [NUM_SOURCES-1:0]       eligible;
    logic [NUM_SOURCES-1:0]       grant;

    logic [1:0]                   rr_ptr;
    logic [1:0]                   winner;
    logic                         any_grant;
    logic                         can_accept;
    wb_result_t                   sel_result;

    assign src_result[0] = exec_result;
    assign src_result[1] = mem_result;
    assign src_result[2] = sys_result;
    assign src_valid     = {sys_valid, mem_valid, exec_valid};

    // Tag lookup for each source's destination
    always_comb begin
        for (int i = 0; i < NUM_SOURCES; i++) begin
            rd_addr[i]  = src_result[i].dest;
            eligible[i] = src_valid[i] && (rd_status[i] == src_result[i].status);
        end
    end

    // Output slot free now or being drained this cycle
    assign can_accept = table_ready && (!out_valid || out_ready);

    // First eligible source at or after the pointer
    always_comb begin
        logic [2:0] idx_sum;
        logic [1:0] idx;

        any_grant = 1'b0;
        winner    = 2'd0;
        grant     = '0;
        for (int k = 0; k < NUM_SOURCES; k++) begin
            idx_sum = {1'b0, rr_ptr} + 3'(k);
            if (idx_sum >= 3'(NUM_SOURCES)) begin
                idx_sum = idx_sum - 3'(NUM_SOURCES);
            end
            idx = idx_sum[1:0];
            if (!any_grant && can_accept && eligible[idx]) begin
                any_grant   = 1'b1;
                winner      = idx;
                grant[idx]  = 1'b1;
            end
        end
    end

    assign exec_ready = grant[0];
    assign mem_ready  = grant[1];
    assign sys_ready  = grant[2];

    assign sel_result = src_result[winner];

    // Bump the tag so the next result for this register can follow
    assign wr_en     = any_grant;
    assign wr_addr   = sel_result.dest;
    assign wr_status = reg_status_t'(sel_result.status + 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            rr_ptr    <= 2'd0;
        end else if (any_grant) begin
            out_valid <= 1'b1;
            rr_ptr    <= (winner == 2'(NUM_SOURCES - 1)) ? 2'd0 : winner + 2'd1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Output payload
    always_ff @(posedge clk) begin
        if (any_grant) begin
            out_result <= sel_result;
        end
    end

    a_single_ready: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({exec_ready, mem_ready, sys_ready})
    ) else $error("writeback_arbiter: more than one source accepted");

    // Stalled output holds its value until taken
    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_result))
    ) else $error("writeback_arbiter: output changed under back-pressure");

endmodule

`default_nettype wire

/* source/writeback_unit.sv */
`timescale 1ns/10ps
`default_nettype none

// Writeback stage, three result sources into one ordered stream
module writeback_unit
    import writeback_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  wire logic        clk,
    input  wire logic        rst,

    input  wire logic        exec_valid,
    output logic             exec_ready,
    input  wire wb_result_t  exec_result,

    input  wire logic        mem_valid,
    output logic             mem_ready,
    input  wire mem_cmd_t    mem_cmd,
    input  wire logic [31:0] mem_data,

    input  wire logic        sys_valid,
    output logic             sys_ready,
    input  wire wb_result_t  sys_result,

    output logic             out_valid,
    input  wire logic        out_ready,
    output wb_result_t       out_result
);

    wb_result_t        mem_result;
    reg_addr_t   [2:0] rd_addr;
    reg_status_t [2:0] rd_status;
    logic              wr_en;
    reg_addr_t         wr_addr;
    reg_status_t       wr_status;
    logic              table_ready;

    load_aligner aligner0 (
        .valid  (mem_valid),
        .cmd    (mem_cmd),
        .data   (mem_data),
        .result (mem_result)
    );

    reg_status_table #(
        .NUM_REGS (NUM_REGS)
    ) status0 (
        .clk         (clk),
        .rst         (rst),
        .rd_addr     (rd_addr),
        .rd_status   (rd_status),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_status   (wr_status),
        .table_ready (table_ready)
    );

    writeback_arbiter arb0 (
        .clk         (clk),
        .rst         (rst),
        .exec_valid  (exec_valid),
        .exec_ready  (exec_ready),
        .exec_result (exec_result),
        .mem_valid   (mem_valid),
        .mem_ready   (mem_ready),
        .mem_result  (mem_result),
        .sys_valid   (sys_valid),
        .sys_ready   (sys_ready),
        .sys_result  (sys_result),
        .rd_addr     (rd_addr),
        .rd_status   (rd_status),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_status   (wr_status),
        .table_ready (table_ready),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_result  (out_result)
    );

endmodule

`default_nettype wire

/* dv/clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

// Free-running testbench clock and a power-on reset
module clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // Release on a rising edge so the DUT sees a whole number of reset cycles
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* dv/writeback_tb.sv */
`timescale 1ns/10ps
`default_nettype none

// Feeds the writeback stage from a trace and checks the ordered output stream
module writeback_tb
    import writeback_pkg::*;
();

    localparam int NUM_REGS      = 32;
    localparam int MAX_PER_REG   = 8;
    localparam int RESET_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT = 4000;

    logic        clk;
    logic        rst;
    logic        exec_valid;
    logic        exec_ready;
    wb_result_t  exec_result;
    logic        mem_valid;
    logic        mem_ready;
    mem_cmd_t    mem_cmd;
    logic [31:0] mem_data;
    logic        sys_valid;
    logic        sys_ready;
    wb_result_t  sys_result;
    logic        out_valid;
    logic        out_ready;
    wb_result_t  out_result;

    // Pending results per source, in trace order
    wb_result_t  exec_q [$];
    wb_result_t  sys_q [$];
    mem_cmd_t    mem_cmd_q [$];
    logic [31:0] mem_data_q [$];

    // Expected values per register, indexed by occurrence
    logic [31:0] exp_value [NUM_REGS * MAX_PER_REG];
    int          exp_count [NUM_REGS];
    int          out_count [NUM_REGS];
    logic [1:0]  accept_tag [NUM_REGS];
    int          miss_count [3];
    logic [2:0]  taken;
    int          total_lines;
    int          total_out;
    int          edges_after_reset;
    logic        hold_pending;
    wb_result_t  held_result;
    logic [31:0] rnd_state;

    clock_gen clock0 (
        .clk (clk),
        .rst (rst)
    );

    writeback_unit #(
        .NUM_REGS (NUM_REGS)
    ) dut0 (
        .clk         (clk),
        .rst         (rst),
        .exec_valid  (exec_valid),
        .exec_ready  (exec_ready),
        .exec_result (exec_result),
        .mem_valid   (mem_valid),
        .mem_ready   (mem_ready),
        .mem_cmd     (mem_cmd),
        .mem_data    (mem_data),
        .sys_valid   (sys_valid),
        .sys_ready   (sys_ready),
        .sys_result  (sys_result),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_result  (out_result)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Select the addressed bytes, then extend
    function automatic logic [31:0] expected_load(input logic [31:0] data,
                                                  input logic [1:0] size,
                                                  input logic is_signed,
                                                  input logic [1:0] offset);
        logic [31:0] v;
        v = data >> (8 * offset);
        case (size)
            2'd0: begin
                v = v & 32'h0000_00ff;
                if (is_signed && v[7]) v = v | 32'hffff_ff00;
            end
            2'd1: begin
                v = v & 32'h0000_ffff;
                if (is_signed && v[15]) v = v | 32'hffff_0000;
            end
            default: ;
        endcase
        return v;
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %h expected %h",
                     $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("Run aborted at %0t ns: %s", $time, reason);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic read_trace();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_src, f_dest, f_tag, f_data, f_size, f_sign, f_off, f_exp;
        logic [31:0] value;
        wb_result_t  res;
        mem_cmd_t    cmd;
        fd = $fopen("dv/writeback_trace.txt", "r");
        if (fd == 0) abort_run("could not open dv/writeback_trace.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                        f_src, f_dest, f_tag, f_data, f_size, f_sign, f_off, f_exp);
            if (n != 8) continue;
            if (f_dest >= NUM_REGS || exp_count[f_dest] >= MAX_PER_REG) begin
                abort_run("trace line with a bad destination register");
            end
            if (f_src == 1) begin
                value         = expected_load(f_data, f_size[1:0], f_sign[0], f_off[1:0]);
                cmd.dest      = f_dest[4:0];
                cmd.status    = f_tag[1:0];
                cmd.size      = load_size_t'(f_size[1:0]);
                cmd.is_signed = f_sign[0];
                cmd.offset    = f_off[1:0];
                mem_cmd_q.push_back(cmd);
                mem_data_q.push_back(f_data);
            end else begin
                value      = f_data;
                res.dest   = f_dest[4:0];
                res.status = f_tag[1:0];
                res.value  = f_data;
                if (f_src == 0) exec_q.push_back(res);
                else if (f_src == 2) sys_q.push_back(res);
                else abort_run("trace line with an unknown source");
            end
            check_value(f_exp, value,
                        $sformatf("trace line %0d expected column", total_lines + 1));
            exp_value[f_dest * MAX_PER_REG + exp_count[f_dest]] = value;
            exp_count[f_dest]++;
            total_lines++;
        end
        $fclose(fd);
    endtask

    // Next payload once the current one was taken
    task automatic drive_sources();
        if (taken[0] || !exec_valid) begin
            exec_valid = (exec_q.size() > 0);
            if (exec_valid) exec_result = exec_q.pop_front();
        end
        if (taken[1] || !mem_valid) begin
            mem_valid = (mem_cmd_q.size() > 0);
            if (mem_valid) begin
                mem_cmd  = mem_cmd_q.pop_front();
                mem_data = mem_data_q.pop_front();
            end
        end
        if (taken[2] || !sys_valid) begin
            sys_valid = (sys_q.size() > 0);
            if (sys_valid) sys_result = sys_q.pop_front();
        end
        taken = '0;
    endtask

    task automatic check_output(input wb_result_t res);
        int r;
        int k;
        r = res.dest;
        k = out_count[r];
        check_value(k < exp_count[r], 1, $sformatf("extra output for x%0d", r));
        check_value(res.status, k % 4, $sformatf("tag order on x%0d", r));
        check_value(res.value, exp_value[r * MAX_PER_REG + k],
                    $sformatf("value of x%0d tag %0d", r, res.status));
        out_count[r]++;
        total_out++;
    endtask

    // Sample everything on the rising edge, inputs settled since the falling edge
    always @(posedge clk) begin : monitor
        logic [2:0]  ready_now;
        logic [2:0]  valid_now;
        logic [2:0]  elig;
        reg_addr_t   head_dest [3];
        reg_status_t head_tag [3];
        ready_now    = {sys_ready, mem_ready, exec_ready};
        valid_now    = {sys_valid, mem_valid, exec_valid};
        head_dest[0] = exec_result.dest;
        head_tag[0]  = exec_result.status;
        head_dest[1] = mem_cmd.dest;
        head_tag[1]  = mem_cmd.status;
        head_dest[2] = sys_result.dest;
        head_tag[2]  = sys_result.status;
        if (rst) begin
            edges_after_reset = 0;
        end else begin
            edges_after_reset++;
            if (edges_after_reset <= NUM_REGS) begin
                check_value({ready_now, out_valid}, 0, "activity during status sweep");
            end
            if (hold_pending) begin
                check_value(out_valid, 1, "out_valid dropped under back-pressure");
                check_value(out_result, held_result, "out_result moved under back-pressure");
            end
            if (out_valid && !out_ready) begin
                check_value(ready_now, 0, "source accepted while output stalled");
                hold_pending = 1'b1;
                held_result  = out_result;
            end else begin
                hold_pending = 1'b0;
            end
            if (out_valid && out_ready) check_output(out_result);
            check_value(ready_now & ~valid_now, 0, "ready without valid");
            if (ready_now != 3'b000) begin
                for (int i = 0; i < 3; i++) begin
                    elig[i] = valid_now[i] && (head_tag[i] == accept_tag[head_dest[i]]);
                end
                for (int i = 0; i < 3; i++) begin
                    if (ready_now[i]) begin
                        check_value(head_tag[i], accept_tag[head_dest[i]],
                                    $sformatf("source %0d accepted a tag out of order", i));
                        accept_tag[head_dest[i]] = accept_tag[head_dest[i]] + 2'd1;
                        taken[i]      = 1'b1;
                        miss_count[i] = 0;
                    end else if (elig[i]) begin
                        miss_count[i]++;
                        check_value(miss_count[i] < 3, 1,
                                    $sformatf("source %0d passed over three times", i));
                    end else begin
                        miss_count[i] = 0;
                    end
                end
            end
        end
    end

    initial begin
        int wait_cycles;
        exec_valid        = 1'b0;
        exec_result       = '0;
        mem_valid         = 1'b0;
        mem_cmd           = '0;
        mem_data          = '0;
        sys_valid         = 1'b0;
        sys_result        = '0;
        out_ready         = 1'b0;
        taken             = '0;
        hold_pending      = 1'b0;
        held_result       = '0;
        total_lines       = 0;
        total_out         = 0;
        edges_after_reset = 0;
        rnd_state         = 32'd73;
        for (int r = 0; r < NUM_REGS; r++) begin
            exp_count[r]  = 0;
            out_count[r]  = 0;
            accept_tag[r] = 2'd0;
        end
        for (int i = 0; i < 3; i++) begin
            miss_count[i] = 0;
        end
        read_trace();

        wait_cycles = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > RESET_TIMEOUT) abort_run("reset was never released");
        end

        // Sources stay valid from here, out_ready high about three cycles in four
        wait_cycles = 0;
        while (total_out < total_lines) begin
            @(negedge clk);
            drive_sources();
            rnd_state = xorshift32(rnd_state);
            out_ready = (rnd_state[1:0] != 2'b00);
            wait_cycles++;
            if (wait_cycles > DRAIN_TIMEOUT) abort_run("trace did not drain in time");
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* writeback_unit.f */
common/writeback_pkg.sv
writeback/load_aligner.sv
writeback/reg_status_table.sv
writeback/writeback_arbiter.sv
source/writeback_unit.sv
dv/clock_gen.sv
dv/writeback_tb.sv

/* dv/writeback_trace.txt */
# src dest tag data size sign offset expected, all hex
# src 0 execute, 1 load, 2 system; size 0 byte, 1 half, 2 word
0 05 0 00000011 2 0 0 00000011
1 05 1 8899aabb 0 1 0 ffffffbb
2 05 2 00000033 2 0 0 00000033
0 06 0 00000101 2 0 0 00000101
2 07 0 00000202 2 0 0 00000202
1 08 0 8899aabb 0 1 1 ffffffaa
0 05 3 00000044 2 0 0 00000044
1 05 0 8899aabb 0 0 2 00000099
1 09 0 12345678 0 0 0 00000078
0 14 0 cafe0001 2 0 0 cafe0001
2 16 0 5a5a0001 2 0 0 5a5a0001
1 0a 0 12f4d678 0 0 1 000000d6
0 15 0 cafe0002 2 0 0 cafe0002
2 17 0 5a5a0002 2 0 0 5a5a0002
1 0b 0 12345678 0 1 2 00000034
0 06 1 00000102 2 0 0 00000102
2 07 1 00000203 2 0 0 00000203
1 0c 0 80345678 0 1 3 ffffff80
1 0d 0 f0000000 0 0 3 000000f0
1 0e 0 1234c001 1 1 0 ffffc001
1 0f 0 1234c001 1 0 0 0000c001
1 10 0 9abc1234 1 1 2 ffff9abc
1 11 0 80011234 1 0 2 00008001
1 12 0 deadbeef 2 1 0 deadbeef
1 13 0 01234567 2 0 0 01234567
